// File: files.f
cpu_pkg.sv
mem_req_if.sv
program_counter.sv
instruction_register.sv
register_file.sv
alu.sv
control_unit.sv
load_store.sv
cpu_top.sv
tb_cpu_top.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_cpu_top
RTL_TOP   ?= cpu_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_top;

  localparam int MAX_DELAY = 3;   // ack delay in cycles, 0 to 3.
  localparam int CPI_BOUND = 12;  // cycles per instruction budget.
  localparam logic [31:0] BASE = 32'h400;

  logic                   clk;
  logic                   rst_n;
  logic                   bus_ack;
  cpu_pkg::word_t         bus_rdata;
  logic                   bus_req;
  cpu_pkg::word_t         bus_addr;
  cpu_pkg::word_t         bus_wdata;
  logic                   bus_write;
  cpu_pkg::size_t         bus_size;
  logic                   halt;

  logic [7:0]     mem [0:4095];   // byte memory, 4 KiB.
  logic [31:0]    prog [$];
  logic [31:0]    st_addr [$];    // store log.
  logic [31:0]    st_data [$];
  logic [31:0]    exp_alu [19];
  logic [31:0]    rng = 32'h1cca;
  int             wait_cnt;
  int             cur_delay;
  int             fixed_delay;
  bit             rand_delay;
  bit             late_req;       // request seen after halt.
  int             errors;
  int             checks;
  int             tests;

  // alu op table, register form then immediate form.
  int r_f3  [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
  int r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
  int i_f3  [9]  = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
  int i_alt [9]  = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
  int i_imm [9]  = '{-7, -1, -1, 'h5a5, 'h0f0, 'h7ff, 7, 9, 'h409};

  cpu_top i_dut (
    .i_clk(clk), .i_rst_n(rst_n), .i_bus_ack(bus_ack), .i_bus_rdata(bus_rdata),
    .o_bus_req(bus_req), .o_bus_addr(bus_addr), .o_bus_wdata(bus_wdata),
    .o_bus_write(bus_write), .o_bus_size(bus_size), .o_halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int next_delay();
    if (!rand_delay) return fixed_delay;
    rng = xorshift(rng);
    return int'(rng % (MAX_DELAY + 1));
  endfunction

  // memory model, answers req after the chosen delay.
  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      bus_ack  = 1'b0;
      wait_cnt = 0;
    end else if (bus_ack) begin
      if (!bus_req) bus_ack = 1'b0; // four-phase release.
    end else if (bus_req) begin
      if (halt) late_req = 1'b1;
      if (wait_cnt < cur_delay) begin
        wait_cnt++;
      end else begin
        if (bus_write) begin
          for (int i = 0; i < (1 << bus_size); i++)
            mem[(bus_addr + i) & 32'hfff] = bus_wdata[8*i +: 8];
          st_addr.push_back(bus_addr);
          st_data.push_back(bus_wdata);
        end else begin
          bus_rdata = '0;
          for (int i = 0; i < (1 << bus_size); i++)
            bus_rdata[8*i +: 8] = mem[(bus_addr + i) & 32'hfff];
        end
        bus_ack   = 1'b1;
        wait_cnt  = 0;
        cur_delay = next_delay();
      end
    end
  end

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
  endfunction

  // instruction encoders per format.
  function automatic logic [31:0] enc_r(input bit alt, input int rs2, rs1, f3, rd);
    return {alt ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), cpu_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, rs1, f3, rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, rs2, rs1, f3);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], cpu_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, rs2, rs1, f3);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], cpu_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd);
    return {imm, 5'(rd), cpu_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, rd);
    logic [20:0] v;
    v = 21'(imm);
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), cpu_pkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] sext8(input logic [7:0] b);
    return {{24{b[7]}}, b};
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] h);
    return {{16{h[15]}}, h};
  endfunction

  // rv32i integer rules, alt selects sub or arithmetic shift.
  function automatic logic [31:0] alu_expect(input int f3, input bit alt,
                                             input logic [31:0] a, b);
    case (f3)
      0:       return alt ? a - b : a + b;
      1:       return a << b[4:0];
      2:       return {31'b0, $signed(a) < $signed(b)};
      3:       return {31'b0, a < b};
      4:       return a ^ b;
      5:       return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6:       return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  task automatic load_program();
    for (int a = 0; a < 4096; a++)
      mem[a] = 8'(a) ^ 8'(a >> 4); // unwritten bytes differ per address.
    foreach (prog[i])
      {mem[4*i + 3], mem[4*i + 2], mem[4*i + 1], mem[4*i]} = prog[i];
    st_addr.delete();
    st_data.delete();
    late_req = 1'b0;
  endtask

  // budget scales with the program length and the worst ack delay.
  task automatic run_until_halt(input string name);
    int limit;
    int cycles;
    limit  = prog.size() * CPI_BOUND * (MAX_DELAY + 1);
    cycles = 0;
    apply_reset();
    while (!halt && cycles <= limit) begin
      @(posedge clk);
      #2 cycles++;
    end
    if (!halt) begin
      $display("%s: core did not halt within %0d cycles", name, limit);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      repeat (20) @(posedge clk); // watch for requests after halt.
      if (late_req) begin
        errors++;
        $display("%s: bus request issued after halt", name);
      end
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("%s finished, %0d errors", name, errors - err_before);
  endtask

  task automatic test_reset();
    int e0;
    int n;
    e0 = errors;
    rst_n = 1'b0;
    repeat (10) begin
      @(posedge clk);
      #2 check("test_reset req", 1'b0, bus_req);
      check("test_reset halt", 1'b0, halt);
    end
    rst_n = 1'b1;
    n = 0;
    while (!bus_req && n < 20) begin
      @(posedge clk);
      #2 n++;
    end
    if (!bus_req) begin
      errors++;
      $display("test_reset: no fetch request after reset");
    end
    check("test_reset addr", cpu_pkg::RESET_PC, bus_addr);
    check("test_reset write", 1'b0, bus_write);
    check("test_reset size", cpu_pkg::SZ_WORD, bus_size);
    check("test_reset halt", 1'b0, halt);
    report("test_reset", e0);
  endtask

  task automatic build_alu_program();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'h8765_4321;
    b = 32'hffff_fff3;  // -13.
    prog.delete();
    prog.push_back(enc_u(20'h87654, 1));
    prog.push_back(enc_i('h321, 1, 0, 1, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(-13, 0, 0, 2, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(BASE, 0, 0, 5, cpu_pkg::OPC_OPIMM));
    for (int k = 0; k < 10; k++) begin
      prog.push_back(enc_r(r_alt[k], 2, 1, r_f3[k], 10));
      prog.push_back(enc_s(4*k, 10, 5, 2));
      exp_alu[k] = alu_expect(r_f3[k], r_alt[k], a, b);
    end
    for (int k = 0; k < 9; k++) begin
      prog.push_back(enc_i(i_imm[k], 1, i_f3[k], 10, cpu_pkg::OPC_OPIMM));
      prog.push_back(enc_s(40 + 4*k, 10, 5, 2));
      exp_alu[10 + k] = alu_expect(i_f3[k], i_alt[k], a, 32'(i_imm[k])); // 12-bit sign ext.
    end
    prog.push_back(32'h0000_0073); // ecall.
  endtask

  task automatic check_alu_results(input string name);
    check({name, " store count"}, 19, st_addr.size());
    for (int k = 0; k < 19; k++) begin
      check(name, exp_alu[k], mem_word(BASE + 4*k));
      if (k < st_addr.size()) begin // bus writes in program order.
        check({name, " store addr"}, BASE + 4*k, st_addr[k]);
        check({name, " store data"}, exp_alu[k], st_data[k]);
      end
    end
  endtask

  task automatic test_alu();
    int e0;
    e0 = errors;
    build_alu_program();
    load_program();
    run_until_halt("test_alu");
    check_alu_results("test_alu");
    report("test_alu", e0);
  endtask

  task automatic test_load_store();
    int          e0;
    int          ld_f3 [11] = '{0, 4, 1, 5, 2, 0, 4, 2, 2, 1, 5};
    int          ld_off [11] = '{0, 0, 0, 0, 0, 3, 3, 16, 20, 22, 2};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp [11];
    e0 = errors;
    a = 32'h89AB_CDEF;
    b = 32'h0000_0655;
    prog.delete();
    prog.push_back(enc_u(20'h89ABD, 1));
    prog.push_back(enc_i(-'h211, 1, 0, 1, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i('h655, 0, 0, 2, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(BASE, 0, 0, 5, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_s(0, 1, 5, 2));  // sw.
    prog.push_back(enc_s(16, 1, 5, 2));
    prog.push_back(enc_s(17, 2, 5, 0)); // sb into the middle.
    prog.push_back(enc_s(20, 1, 5, 2));
    prog.push_back(enc_s(22, 2, 5, 1)); // sh upper half.
    for (int k = 0; k < 11; k++) begin
      prog.push_back(enc_i(ld_off[k], 5, ld_f3[k], 10, cpu_pkg::OPC_LOAD));
      prog.push_back(enc_s('h80 + 4*k, 10, 5, 2));
    end
    prog.push_back(32'h0000_0073);
    exp = '{sext8(a[7:0]), {24'b0, a[7:0]}, sext16(a[15:0]), {16'b0, a[15:0]}, a,
            sext8(a[31:24]), {24'b0, a[31:24]}, {a[31:16], b[7:0], a[7:0]},
            {b[15:0], a[15:0]}, sext16(b[15:0]), {16'b0, a[31:16]}};
    load_program();
    run_until_halt("test_load_store");
    check("test_load_store word 0x410", {a[31:16], b[7:0], a[7:0]}, mem_word(BASE + 16));
    check("test_load_store word 0x414", {b[15:0], a[15:0]}, mem_word(BASE + 20));
    for (int k = 0; k < 11; k++)
      check("test_load_store", exp[k], mem_word(BASE + 'h80 + 4*k));
    report("test_load_store", e0);
  endtask

  task automatic test_branch_jump();
    int          e0;
    int          call_pc;
    int          br [12][4]; // f3, rs1, rs2, taken.
    e0 = errors;
    br = '{'{0, 4, 4, 1}, '{0, 3, 4, 0}, '{4, 3, 4, 1}, '{4, 4, 3, 0},
           '{5, 4, 3, 1}, '{5, 3, 4, 0}, '{6, 4, 3, 1}, '{6, 3, 4, 0},
           '{7, 3, 4, 1}, '{7, 4, 3, 0}, '{1, 3, 4, 1}, '{1, 4, 4, 0}};
    prog.delete();
    prog.push_back(enc_i(BASE, 0, 0, 5, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(10, 0, 0, 2, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(-1, 0, 0, 3, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(1, 0, 0, 4, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_r(0, 2, 1, 0, 1));                   // sum += n.
    prog.push_back(enc_i(-1, 2, 0, 2, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_b(-8, 0, 2, 1));                     // bne loop.
    for (int k = 0; k < 12; k++) begin
      prog.push_back(enc_b(8, br[k][2], br[k][1], br[k][0]));
      // x7 counts wrongly fallen-through taken branches, x8 counts not taken.
      prog.push_back(enc_i(1, br[k][3] ? 7 : 8, 0, br[k][3] ? 7 : 8, cpu_pkg::OPC_OPIMM));
    end
    call_pc = 4 * prog.size();
    prog.push_back(enc_j(8, 9));                            // call.
    prog.push_back(enc_j(12, 0));                           // skip over callee.
    prog.push_back(enc_i(77, 0, 0, 11, cpu_pkg::OPC_OPIMM));
    prog.push_back(enc_i(1, 9, 0, 0, cpu_pkg::OPC_JALR));   // odd offset, bit 0 dropped.
    prog.push_back(enc_s(0, 1, 5, 2));
    prog.push_back(enc_s(4, 9, 5, 2));
    prog.push_back(enc_s(8, 7, 5, 2));
    prog.push_back(enc_s(12, 8, 5, 2));
    prog.push_back(enc_s(16, 11, 5, 2));
    prog.push_back(32'h0000_0073);
    load_program();
    run_until_halt("test_branch_jump");
    check("test_branch_jump sum", 55, mem_word(BASE));
    check("test_branch_jump link", call_pc + 4, mem_word(BASE + 4));
    check("test_branch_jump taken", 0, mem_word(BASE + 8));
    check("test_branch_jump not taken", 6, mem_word(BASE + 12));
    check("test_branch_jump callee", 77, mem_word(BASE + 16));
    report("test_branch_jump", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    rand_delay = 1'b1;
    build_alu_program();
    load_program();
    run_until_halt("test_backpressure");
    check_alu_results("test_backpressure");
    rand_delay = 1'b0;
    report("test_backpressure", e0);
  endtask

  initial begin
    rst_n       = 1'b0;
    bus_ack     = 1'b0;
    bus_rdata   = '0;
    fixed_delay = 1;
    cur_delay   = 1;
    wait_cnt    = 0;
    rand_delay  = 1'b0;
    late_req    = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_reset();
    test_alu();
    test_load_store();
    test_branch_jump();
    test_backpressure();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
  input  wire            i_clk,
  input  wire            i_rst_n,
  input  wire            i_bus_ack,
  input  cpu_pkg::word_t i_bus_rdata,
  output wire            o_bus_req,
  output cpu_pkg::word_t o_bus_addr,
  output cpu_pkg::word_t o_bus_wdata,
  output wire            o_bus_write,
  output cpu_pkg::size_t o_bus_size,
  output wire            o_halt
);

  mem_req_if mem_if ();

  cpu_pkg::word_t    w_pc, w_imm, w_rs1_data, w_rs2_data, w_rf_wdata;
  cpu_pkg::word_t    w_alu_result, w_jump_addr;
  cpu_pkg::reg_idx_t w_rd, w_rs1, w_rs2;
  wire [6:0]         w_opcode;
  wire [2:0]         w_funct3;
  wire               w_funct7_b5, w_jump, w_ir_load, w_pc_load, w_rf_we, w_alu_capture;

  // raw word port left open, fields are decoded inside.
  instruction_register m_ir (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_load(w_ir_load),
    .i_word(mem_if.rdata), .o_instr(), .o_opcode(w_opcode), .o_rd(w_rd), .o_rs1(w_rs1),
    .o_rs2(w_rs2), .o_funct3(w_funct3), .o_funct7_b5(w_funct7_b5), .o_imm(w_imm));

  program_counter m_pc (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_load(w_pc_load),
    .i_jump(w_jump), .i_jump_addr(w_jump_addr), .o_pc(w_pc));

  register_file m_rf (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(w_rf_we), .i_rs1(w_rs1),
    .i_rs2(w_rs2), .i_rd(w_rd), .i_wdata(w_rf_wdata), .o_rs1_data(w_rs1_data),
    .o_rs2_data(w_rs2_data));

  alu m_alu (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_capture(w_alu_capture),
    .i_opcode(w_opcode), .i_funct3(w_funct3), .i_funct7_b5(w_funct7_b5), .i_a(w_rs1_data),
    .i_b(w_rs2_data), .i_imm(w_imm), .i_pc(w_pc), .o_result(w_alu_result),
    .o_jump(w_jump), .o_jump_addr(w_jump_addr));

  control_unit m_ctrl (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_opcode(w_opcode),
    .i_funct3(w_funct3), .i_pc(w_pc), .i_alu_result(w_alu_result), .i_rs2_data(w_rs2_data),
    .o_ir_load(w_ir_load), .o_pc_load(w_pc_load), .o_rf_we(w_rf_we), .o_rf_wdata(w_rf_wdata),
    .o_alu_capture(w_alu_capture), .o_halt(o_halt), .mem(mem_if.master));

  // sole master on the external bus.
  load_store m_lsu (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_bus_ack(i_bus_ack),
    .i_bus_rdata(i_bus_rdata), .o_bus_req(o_bus_req), .o_bus_addr(o_bus_addr),
    .o_bus_wdata(o_bus_wdata), .o_bus_write(o_bus_write), .o_bus_size(o_bus_size),
    .mem(mem_if.slave));

endmodule

`default_nettype wire

// File: load_store.sv
`timescale 1ns/1ns
`default_nettype none

module load_store (
  input  wire            i_clk,
  input  wire            i_rst_n,
  input  wire            i_bus_ack,
  input  cpu_pkg::word_t i_bus_rdata,
  output logic           o_bus_req,
  output cpu_pkg::word_t o_bus_addr,
  output cpu_pkg::word_t o_bus_wdata,
  output logic           o_bus_write,
  output cpu_pkg::size_t o_bus_size,
  mem_req_if.slave       mem
);

  typedef enum logic [1:0] {LS_IDLE, LS_REQ, LS_REL} ls_state_t;

  ls_state_t      state;
  logic           uns_q;     // captured signedness.
  cpu_pkg::word_t st_data;
  cpu_pkg::word_t ld_data;

  // right-aligned store data, upper bytes cleared.
  always_comb begin
    case (mem.size)
      cpu_pkg::SZ_BYTE: st_data = {24'b0, mem.wdata[7:0]};
      cpu_pkg::SZ_HALF: st_data = {16'b0, mem.wdata[15:0]};
      default:          st_data = mem.wdata;
    endcase
  end

  // load extension on the live bus data.
  always_comb begin
    case (o_bus_size)
      cpu_pkg::SZ_BYTE: ld_data = {{24{!uns_q && i_bus_rdata[7]}}, i_bus_rdata[7:0]};
      cpu_pkg::SZ_HALF: ld_data = {{16{!uns_q && i_bus_rdata[15]}}, i_bus_rdata[15:0]};
      default:          ld_data = i_bus_rdata;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= LS_IDLE;
      o_bus_req   <= 1'b0;
      o_bus_write <= 1'b0;
      o_bus_size  <= cpu_pkg::SZ_WORD;
      uns_q       <= 1'b0;
      mem.done    <= 1'b0;
    end else begin
      mem.done <= 1'b0; // pulse.
      case (state)
        LS_IDLE: if (mem.start) begin
          o_bus_req   <= 1'b1; // req the cycle after start.
          o_bus_write <= mem.write;
          o_bus_size  <= mem.size;
          uns_q       <= mem.is_unsigned;
          state       <= LS_REQ;
        end
        LS_REQ: if (i_bus_ack) begin
          o_bus_req <= 1'b0; // data sampled, release.
          state     <= LS_REL;
        end
        LS_REL: if (!i_bus_ack) begin
          o_bus_write <= 1'b0;
          mem.done    <= 1'b1; // ack seen low.
          state       <= LS_IDLE;
        end
        default: state <= LS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == LS_IDLE && mem.start) begin
      o_bus_addr  <= mem.addr;
      o_bus_wdata <= st_data;
    end
    if (state == LS_REQ && i_bus_ack)
      mem.rdata <= ld_data;
  end

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
  input  wire            i_clk,
  input  wire            i_rst_n,
  input  wire [6:0]      i_opcode,
  input  wire [2:0]      i_funct3,
  input  cpu_pkg::word_t i_pc,
  input  cpu_pkg::word_t i_alu_result,
  input  cpu_pkg::word_t i_rs2_data,
  output logic           o_ir_load,
  output logic           o_pc_load,
  output logic           o_rf_we,
  output cpu_pkg::word_t o_rf_wdata,
  output logic           o_alu_capture,
  output logic           o_halt,
  mem_req_if.master      mem
);

  cpu_pkg::ctrl_state_t state;
  cpu_pkg::ctrl_state_t state_nxt;
  cpu_pkg::word_t       ld_data;   // load result held for writeback.
  logic                 busy;      // request open on load_store.
  logic                 fetch;
  logic                 is_mem;
  logic                 writes_rd;

  assign fetch  = (state == cpu_pkg::S_FETCH);
  assign is_mem = (i_opcode == cpu_pkg::OPC_LOAD) || (i_opcode == cpu_pkg::OPC_STORE);

  // only these groups have a destination.
  assign writes_rd = (i_opcode == cpu_pkg::OPC_LUI)  || (i_opcode == cpu_pkg::OPC_AUIPC) ||
                     (i_opcode == cpu_pkg::OPC_JAL)  || (i_opcode == cpu_pkg::OPC_JALR)  ||
                     (i_opcode == cpu_pkg::OPC_LOAD) || (i_opcode == cpu_pkg::OPC_OPIMM) ||
                     (i_opcode == cpu_pkg::OPC_OP);

  always_comb begin
    state_nxt = state;
    case (state)
      cpu_pkg::S_FETCH:     if (mem.done) state_nxt = cpu_pkg::S_DECODE;
      cpu_pkg::S_DECODE:    state_nxt = (i_opcode == cpu_pkg::OPC_SYSTEM) ?
                                        cpu_pkg::S_HALT : cpu_pkg::S_EXECUTE;
      cpu_pkg::S_EXECUTE:   state_nxt = is_mem ? cpu_pkg::S_MEMORY : cpu_pkg::S_WRITEBACK;
      cpu_pkg::S_MEMORY:    if (mem.done) state_nxt = cpu_pkg::S_WRITEBACK;
      cpu_pkg::S_WRITEBACK: state_nxt = cpu_pkg::S_FETCH;
      default:              state_nxt = cpu_pkg::S_HALT; // stays until reset.
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= cpu_pkg::S_FETCH;
      busy  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (mem.start)
        busy <= 1'b1;
      else if (mem.done)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == cpu_pkg::S_MEMORY && mem.done)
      ld_data <= mem.rdata;
  end

  // one start per fetch or memory state.
  assign mem.start       = (fetch || state == cpu_pkg::S_MEMORY) && !busy;
  assign mem.write       = !fetch && (i_opcode == cpu_pkg::OPC_STORE);
  assign mem.addr        = fetch ? i_pc : i_alu_result;
  assign mem.wdata       = i_rs2_data;
  assign mem.size        = fetch ? cpu_pkg::SZ_WORD : cpu_pkg::size_t'(i_funct3[1:0]);
  assign mem.is_unsigned = !fetch && i_funct3[2]; // lbu, lhu.

  assign o_ir_load     = fetch && mem.done;
  assign o_alu_capture = (state == cpu_pkg::S_EXECUTE);
  assign o_pc_load     = (state == cpu_pkg::S_WRITEBACK);
  assign o_rf_we       = (state == cpu_pkg::S_WRITEBACK) && writes_rd;
  assign o_rf_wdata    = (i_opcode == cpu_pkg::OPC_LOAD) ? ld_data : i_alu_result;
  assign o_halt        = (state == cpu_pkg::S_HALT);

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire            i_clk,
  input  wire            i_rst_n,
  input  wire            i_capture,   // end of execute.
  input  wire [6:0]      i_opcode,
  input  wire [2:0]      i_funct3,
  input  wire            i_funct7_b5,
  input  cpu_pkg::word_t i_a,         // rs1 data.
  input  cpu_pkg::word_t i_b,         // rs2 data.
  input  cpu_pkg::word_t i_imm,
  input  cpu_pkg::word_t i_pc,
  output cpu_pkg::word_t o_result,
  output logic           o_jump,
  output cpu_pkg::word_t o_jump_addr
);

  cpu_pkg::word_t opnd_b;
  cpu_pkg::word_t arith;
  cpu_pkg::word_t result;
  cpu_pkg::word_t target;
  cpu_pkg::word_t pc_imm;
  cpu_pkg::word_t a_imm;
  logic [4:0]     shamt;
  logic           taken;
  logic           jump;

  assign opnd_b = (i_opcode == cpu_pkg::OPC_OP) ? i_b : i_imm; // reg or imm.
  assign shamt  = opnd_b[4:0];
  assign pc_imm = i_pc + i_imm;
  assign a_imm  = i_a + i_imm; // address and jalr base.

  always_comb begin
    case (i_funct3)
      cpu_pkg::F3_ADD:  arith = (i_opcode == cpu_pkg::OPC_OP && i_funct7_b5) ?
                                i_a - opnd_b : i_a + opnd_b; // sub only for reg op.
      cpu_pkg::F3_SLL:  arith = i_a << shamt;
      cpu_pkg::F3_SLT:  arith = {31'b0, $signed(i_a) < $signed(opnd_b)};
      cpu_pkg::F3_SLTU: arith = {31'b0, i_a < opnd_b};
      cpu_pkg::F3_XOR:  arith = i_a ^ opnd_b;
      cpu_pkg::F3_SR:   arith = i_funct7_b5 ? cpu_pkg::word_t'($signed(i_a) >>> shamt) :
                                i_a >> shamt;
      cpu_pkg::F3_OR:   arith = i_a | opnd_b;
      default:          arith = i_a & opnd_b;
    endcase
  end

  always_comb begin
    case (i_funct3)
      cpu_pkg::F3_BEQ:  taken = (i_a == i_b);
      cpu_pkg::F3_BNE:  taken = (i_a != i_b);
      cpu_pkg::F3_BLT:  taken = ($signed(i_a) < $signed(i_b));
      cpu_pkg::F3_BGE:  taken = ($signed(i_a) >= $signed(i_b));
      cpu_pkg::F3_BLTU: taken = (i_a < i_b);
      cpu_pkg::F3_BGEU: taken = (i_a >= i_b);
      default:          taken = 1'b0; // reserved encodings.
    endcase
  end

  always_comb begin
    jump   = 1'b0;
    target = pc_imm;
    case (i_opcode)
      cpu_pkg::OPC_LUI:    result = i_imm;
      cpu_pkg::OPC_AUIPC:  result = pc_imm;
      cpu_pkg::OPC_JAL: begin
        result = i_pc + 32'd4; // link value.
        jump   = 1'b1;
      end
      cpu_pkg::OPC_JALR: begin
        result = i_pc + 32'd4;
        jump   = 1'b1;
        target = {a_imm[31:1], 1'b0}; // bit 0 cleared.
      end
      cpu_pkg::OPC_BRANCH: begin
        result = pc_imm;
        jump   = taken;
      end
      cpu_pkg::OPC_LOAD,
      cpu_pkg::OPC_STORE:  result = a_imm; // effective address.
      default:             result = arith;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_result    <= '0;
      o_jump      <= 1'b0;
      o_jump_addr <= '0;
    end else if (i_capture) begin
      o_result    <= result;
      o_jump      <= jump;
      o_jump_addr <= target;
    end
  end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire               i_we,
  input  cpu_pkg::reg_idx_t i_rs1,
  input  cpu_pkg::reg_idx_t i_rs2,
  input  cpu_pkg::reg_idx_t i_rd,
  input  cpu_pkg::word_t    i_wdata,
  output cpu_pkg::word_t    o_rs1_data,
  output cpu_pkg::word_t    o_rs2_data
);

  cpu_pkg::word_t regs [32];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (i_we && (i_rd != 5'd0)) begin // x0 stays zero.
      regs[i_rd] <= i_wdata;
    end
  end

  // async reads, x0 forced to zero.
  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: instruction_register.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_register (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire               i_load,     // fetch done.
  input  cpu_pkg::word_t    i_word,
  output cpu_pkg::word_t    o_instr,
  output logic [6:0]        o_opcode,
  output cpu_pkg::reg_idx_t o_rd,
  output cpu_pkg::reg_idx_t o_rs1,
  output cpu_pkg::reg_idx_t o_rs2,
  output logic [2:0]        o_funct3,
  output logic              o_funct7_b5,
  output cpu_pkg::word_t    o_imm
);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_instr <= '0;
    else if (i_load)
      o_instr <= i_word;
  end

  // fixed field positions.
  assign o_opcode    = o_instr[6:0];
  assign o_rd        = o_instr[11:7];
  assign o_funct3    = o_instr[14:12];
  assign o_rs1       = o_instr[19:15];
  assign o_rs2       = o_instr[24:20];
  assign o_funct7_b5 = o_instr[30];

  // immediate format follows the opcode, sign bit is always instr[31].
  always_comb begin
    case (o_opcode)
      cpu_pkg::OPC_STORE:  o_imm = {{20{o_instr[31]}}, o_instr[31:25], o_instr[11:7]};
      cpu_pkg::OPC_BRANCH: o_imm = {{19{o_instr[31]}}, o_instr[31], o_instr[7],
                                    o_instr[30:25], o_instr[11:8], 1'b0};
      cpu_pkg::OPC_LUI,
      cpu_pkg::OPC_AUIPC:  o_imm = {o_instr[31:12], 12'b0}; // u-type.
      cpu_pkg::OPC_JAL:    o_imm = {{11{o_instr[31]}}, o_instr[31], o_instr[19:12],
                                    o_instr[20], o_instr[30:21], 1'b0};
      default:             o_imm = {{20{o_instr[31]}}, o_instr[31:20]}; // i-type.
    endcase
  end

endmodule

`default_nettype wire

// File: program_counter.sv
`timescale 1ns/1ns
`default_nettype none

module program_counter (
  input  wire            i_clk,
  input  wire            i_rst_n,
  input  wire            i_load,      // pulse in writeback.
  input  wire            i_jump,      // taken branch or jump.
  input  cpu_pkg::word_t i_jump_addr,
  output cpu_pkg::word_t o_pc
);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc <= cpu_pkg::RESET_PC;
    end else if (i_load) begin
      if (i_jump)
        o_pc <= i_jump_addr; // target from alu.
      else
        o_pc <= o_pc + 32'd4; // next sequential.
    end
  end

endmodule

`default_nettype wire

// File: mem_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// one open request at a time, start and done are single-cycle pulses.
interface mem_req_if;
  logic           start;        // request pulse.
  logic           write;        // store when high.
  cpu_pkg::word_t addr;
  cpu_pkg::word_t wdata;        // right-aligned store data.
  cpu_pkg::size_t size;
  logic           is_unsigned;  // zero-extend loads.
  logic           done;         // completion pulse.
  cpu_pkg::word_t rdata;        // extended load data, valid with done.

  modport master (output start, write, addr, wdata, size, is_unsigned,
                  input  done, rdata);
  modport slave  (input  start, write, addr, wdata, size, is_unsigned,
                  output done, rdata);
endinterface

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32; // data path width.

  typedef logic [XLEN-1:0] word_t;  // data, address or instruction.
  typedef logic [4:0]      reg_idx_t;
  typedef logic [1:0]      size_t;  // access size code.

  localparam size_t SZ_BYTE = 2'd0;
  localparam size_t SZ_HALF = 2'd1;
  localparam size_t SZ_WORD = 2'd2;

  localparam word_t RESET_PC = 32'h0000_0000;

  // major opcodes.
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 for OP and OP-IMM.
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl or sra by funct7 bit 5.
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for branches.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [2:0] {
    S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALT
  } ctrl_state_t;

endpackage

`default_nettype wire
